//--- int_cluster_vectors.txt
// columns (hex): op rd rs1 rs2 imm_en imm expected
// op: 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 sll, 6 srl, 7 slt
3 01 3c 3d 0 00000000 00000000
0 02 00 00 1 00001234 00001234
1 03 00 00 1 00000010 fffffff0
4 04 00 00 1 a5a5a5a5 a5a5a5a5
3 05 00 00 1 0f0f00ff 0f0f00ff
2 06 04 00 1 0000ffff 0000a5a5
5 07 02 00 1 00000004 00012340
6 08 03 00 1 00000008 00ffffff
7 09 03 00 1 00000000 00000001
0 0a 02 05 0 00000000 0f0f1333
1 0b 02 03 0 00000000 00001244
5 0e 05 09 0 00000000 1e1e01fe
6 0f 04 03 0 00000000 0000a5a5
3 11 03 02 0 00000000 fffffff4
0 12 11 00 1 00000010 00000004
5 13 12 12 0 00000000 00000040
1 14 13 12 0 00000000 0000003c
4 15 14 13 0 00000000 0000007c
0 16 15 15 0 00000000 000000f8
6 17 16 12 0 00000000 0000000f
2 18 17 14 0 00000000 0000000c
7 19 18 17 0 00000000 00000001

//--- compile.f
cpu_params.sv
int_rs_types.sv
issue_router.sv
int_exec_lane.sv
prf.sv
result_bus.sv
int_cluster.sv
tb_int_cluster.sv

//--- Bender.yml
package:
  name: int_cluster

sources:
  - files:
      - cpu_params.sv
      - int_rs_types.sv
      - issue_router.sv
      - int_exec_lane.sv
      - prf.sv
      - result_bus.sv
      - int_cluster.sv
  - target: test
    files:
      - tb_int_cluster.sv

//--- tb_int_cluster.sv
`timescale 1ns/10ps
`default_nettype none

module tb_int_cluster;

    localparam int NUM_VEC  = 22;
    localparam int VEC_COLS = 7;    // op rd rs1 rs2 imm_en imm expected.

    logic                     clk;
    logic                     rst;
    logic                     issue_valid;
    int_rs_types::issue_pkt_t issue;
    logic                     issue_ready;
    int_rs_types::cdb_prf_t   cmpl [cpu_params::CDB_WIDTH];

    logic [31:0] vec_mem [NUM_VEC*VEC_COLS];
    logic [31:0] exp_val [cpu_params::PRF_DEPTH];
    logic        busy    [cpu_params::PRF_DEPTH];   // issued, not yet seen on cmpl.
    logic [31:0] rand_state = 32'h4a05;
    int          errors     = 0;
    int          completed  = 0;
    bit          stall_seen = 1'b0;

    int_cluster i_int_cluster (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .cmpl        (cmpl)
    );

    always #50 clk = ~clk;

    // ==============================
    // helpers
    // ==============================
    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic report(input string what);
        errors++;
        $display("ERROR t=%0t %s", $time, what);
    endtask

    // match each bus slot to its outstanding op.
    task automatic scan_cmpl();
        for (int s = 0; s < cpu_params::CDB_WIDTH; s++) begin
            for (int t = s + 1; t < cpu_params::CDB_WIDTH; t++) begin
                if (cmpl[s].valid && cmpl[t].valid && cmpl[s].rd_phy == cmpl[t].rd_phy) begin
                    report($sformatf("two bus slots carry p%0d in one cycle", cmpl[s].rd_phy));
                end
            end
            if (cmpl[s].valid) begin
                if (!busy[cmpl[s].rd_phy]) begin
                    report($sformatf("completion for p%0d with no op outstanding",
                                     cmpl[s].rd_phy));
                end else begin
                    check_value($sformatf("cmpl[%0d].rd_value", s),
                                exp_val[cmpl[s].rd_phy], cmpl[s].rd_value);
                    busy[cmpl[s].rd_phy] = 1'b0;
                    completed++;
                end
            end
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        scan_cmpl();
    endtask

    // ==============================
    // stimulus
    // ==============================
    initial begin
        int                           base;
        logic [31:0]                  r;
        logic [cpu_params::PHY_W-1:0] rs1;
        logic [cpu_params::PHY_W-1:0] rs2;
        logic [cpu_params::PHY_W-1:0] rd;
        clk         = 1'b0;
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        for (int i = 0; i < cpu_params::PRF_DEPTH; i++) begin
            busy[i]    = 1'b0;
            exp_val[i] = '0;
        end
        $readmemh("int_cluster_vectors.txt", vec_mem);
        if ($isunknown(vec_mem[NUM_VEC*VEC_COLS-1])) report("vector file is missing or short");
        repeat (4) @(negedge clk);
        rst = 1'b0;
        check_value("issue_ready", 32'd1, {31'd0, issue_ready});
        for (int s = 0; s < cpu_params::CDB_WIDTH; s++) begin
            check_value($sformatf("cmpl[%0d].valid", s), 32'd0, {31'd0, cmpl[s].valid});
        end

        for (int v = 0; v < NUM_VEC; v++) begin
            base = v * VEC_COLS;
            r    = next_random();
            if (r[31:29] == 3'd0) begin    // occasional idle cycle.
                issue_valid = 1'b0;
                next_cycle();
            end
            rd            = vec_mem[base+1][cpu_params::PHY_W-1:0];
            rs1           = vec_mem[base+2][cpu_params::PHY_W-1:0];
            rs2           = vec_mem[base+3][cpu_params::PHY_W-1:0];
            issue.op      = int_rs_types::alu_op_t'(vec_mem[base][2:0]);
            issue.rd_phy  = rd;
            issue.rs1_phy = rs1;
            issue.rs2_phy = rs2;
            issue.rs1_rdy = !busy[rs1];
            issue.rs2_rdy = !busy[rs2];
            issue.imm_en  = vec_mem[base+4][0];
            issue.imm     = vec_mem[base+5];
            if (busy[rd]) report($sformatf("vector %0d reuses busy p%0d", v, rd));
            issue_valid = 1'b1;
            while (!issue_ready) begin
                stall_seen = 1'b1;
                next_cycle();
            end
            busy[rd]    = 1'b1;             // accepted at the coming edge.
            exp_val[rd] = vec_mem[base+6];
            next_cycle();
        end
        issue_valid = 1'b0;

        while (completed < NUM_VEC) next_cycle();
        repeat (10) next_cycle();          // catch late duplicates.
        if (!stall_seen) report("issue_ready never went low during the issue bursts");

        $display("closing: %0d errors, %0d of %0d ops completed", errors, completed, NUM_VEC);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // ==============================
    // watchdog
    // ==============================
    initial begin
        repeat (NUM_VEC * 40 + 100) @(posedge clk);
        errors++;
        $display("ERROR t=%0t ops still outstanding when the time limit ran out", $time);
        $display("closing: %0d errors, %0d of %0d ops completed", errors, completed, NUM_VEC);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- int_cluster.sv
`timescale 1ns/10ps
`default_nettype none

module int_cluster (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     issue_valid,
    input  int_rs_types::issue_pkt_t issue,
    output logic                     issue_ready,
    output int_rs_types::cdb_prf_t   cmpl [cpu_params::CDB_WIDTH]
);

    logic                         lane_idle [cpu_params::NUM_LANES];
    logic                         lane_load [cpu_params::NUM_LANES];
    int_rs_types::issue_pkt_t     lane_pkt;
    int_rs_types::prf_rd_req_t    rd_req    [cpu_params::NUM_LANES];
    int_rs_types::prf_rd_rsp_t    rd_rsp    [cpu_params::NUM_LANES];
    logic                         res_valid [cpu_params::NUM_LANES];
    logic                         res_ready [cpu_params::NUM_LANES];
    int_rs_types::lane_result_t   res       [cpu_params::NUM_LANES];
    int_rs_types::cdb_prf_t       cdb       [cpu_params::CDB_WIDTH];

    // ==============================
    // issue
    // ==============================
    issue_router i_issue_router (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .lane_idle   (lane_idle),
        .lane_load   (lane_load),
        .lane_pkt    (lane_pkt),
        .cdb         (cdb)
    );

    // ==============================
    // lanes
    // ==============================
    for (genvar i = 0; i < cpu_params::NUM_LANES; i++) begin : g_lane
        int_exec_lane i_int_exec_lane (
            .clk       (clk),
            .rst       (rst),
            .load      (lane_load[i]),
            .pkt       (lane_pkt),
            .idle      (lane_idle[i]),
            .cdb       (cdb),
            .rd_req    (rd_req[i]),
            .rd_rsp    (rd_rsp[i]),
            .res_valid (res_valid[i]),
            .res_ready (res_ready[i]),
            .res       (res[i])
        );
    end

    // ==============================
    // writeback
    // ==============================
    result_bus i_result_bus (
        .clk       (clk),
        .rst       (rst),
        .res_valid (res_valid),
        .res       (res),
        .res_ready (res_ready),
        .cdb       (cdb)
    );

    prf i_prf (
        .clk    (clk),
        .rst    (rst),
        .cdb    (cdb),
        .rd_req (rd_req),
        .rd_rsp (rd_rsp)
    );

    assign cmpl = cdb;   // rob always accepts.

endmodule

`default_nettype wire

//--- result_bus.sv
`timescale 1ns/10ps
`default_nettype none

module result_bus (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       res_valid [cpu_params::NUM_LANES],
    input  int_rs_types::lane_result_t res       [cpu_params::NUM_LANES],
    output logic                       res_ready [cpu_params::NUM_LANES],
    output int_rs_types::cdb_prf_t     cdb       [cpu_params::CDB_WIDTH]
);

    logic [cpu_params::LANE_W-1:0] ptr;      // first lane looked at.
    logic [cpu_params::LANE_W-1:0] last;     // last lane granted.
    logic [cpu_params::LANE_W-1:0] ptr_nxt;
    logic                          any_grant;
    int_rs_types::cdb_prf_t        slot [cpu_params::CDB_WIDTH];

    // ==============================
    // grant
    // ==============================
    always_comb begin
        int idx;
        int cnt;
        cnt  = 0;
        last = ptr;
        for (int s = 0; s < cpu_params::CDB_WIDTH; s++) begin
            slot[s] = '0;
        end
        for (int l = 0; l < cpu_params::NUM_LANES; l++) begin
            res_ready[l] = 1'b0;
        end
        for (int k = 0; k < cpu_params::NUM_LANES; k++) begin
            idx = (int'(ptr) + k) % cpu_params::NUM_LANES;
            if (res_valid[idx] && (cnt < cpu_params::CDB_WIDTH)) begin
                res_ready[idx]     = 1'b1;
                slot[cnt].valid    = 1'b1;
                slot[cnt].rd_phy   = res[idx].rd_phy;
                slot[cnt].rd_value = res[idx].rd_value;
                last               = idx[cpu_params::LANE_W-1:0];
                cnt++;
            end
        end
        any_grant = (cnt != 0);
    end

    // start after the last winner next time.
    always_comb begin
        if (int'(last) == cpu_params::NUM_LANES - 1) begin
            ptr_nxt = '0;
        end else begin
            ptr_nxt = last + 1'b1;
        end
    end

    // ==============================
    // bus register
    // ==============================
    always_ff @(posedge clk) begin
        for (int s = 0; s < cpu_params::CDB_WIDTH; s++) begin
            cdb[s].rd_phy   <= slot[s].rd_phy;
            cdb[s].rd_value <= slot[s].rd_value;
        end
        if (rst) begin
            ptr <= '0;
            for (int s = 0; s < cpu_params::CDB_WIDTH; s++) begin
                cdb[s].valid <= 1'b0;
            end
        end else begin
            for (int s = 0; s < cpu_params::CDB_WIDTH; s++) begin
                cdb[s].valid <= slot[s].valid;   // one cycle per slot.
            end
            if (any_grant) ptr <= ptr_nxt;
        end
    end

endmodule

`default_nettype wire

//--- prf.sv
`timescale 1ns/10ps
`default_nettype none

module prf (
    input  logic                      clk,
    input  logic                      rst,
    input  int_rs_types::cdb_prf_t    cdb    [cpu_params::CDB_WIDTH],
    input  int_rs_types::prf_rd_req_t rd_req [cpu_params::NUM_LANES],
    output int_rs_types::prf_rd_rsp_t rd_rsp [cpu_params::NUM_LANES]
);

    logic [cpu_params::XLEN-1:0] regs [cpu_params::PRF_DEPTH];

    // ==============================
    // write ports
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < cpu_params::PRF_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int s = 0; s < cpu_params::CDB_WIDTH; s++) begin
                if (cdb[s].valid) begin
                    regs[cdb[s].rd_phy] <= cdb[s].rd_value;
                end
            end
        end
    end

    // ==============================
    // read ports
    // ==============================
    // a slot on the bus this cycle overrides the stored word.
    always_comb begin
        for (int j = 0; j < cpu_params::NUM_LANES; j++) begin
            rd_rsp[j].rs1_value = regs[rd_req[j].rs1_phy];
            rd_rsp[j].rs2_value = regs[rd_req[j].rs2_phy];

            for (int s = 0; s < cpu_params::CDB_WIDTH; s++) begin
                if (cdb[s].valid && (cdb[s].rd_phy == rd_req[j].rs1_phy)) begin
                    rd_rsp[j].rs1_value = cdb[s].rd_value;
                end

                if (cdb[s].valid && (cdb[s].rd_phy == rd_req[j].rs2_phy)) begin
                    rd_rsp[j].rs2_value = cdb[s].rd_value;
                end
            end
        end
    end

    // p0 is never written so it stays zero.

endmodule

`default_nettype wire

//--- int_exec_lane.sv
`timescale 1ns/10ps
`default_nettype none

module int_exec_lane (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     load,
    input  int_rs_types::issue_pkt_t pkt,
    output logic                     idle,
    input  int_rs_types::cdb_prf_t   cdb [cpu_params::CDB_WIDTH],
    output int_rs_types::prf_rd_req_t rd_req,
    input  int_rs_types::prf_rd_rsp_t rd_rsp,
    output logic                     res_valid,
    input  logic                     res_ready,
    output int_rs_types::lane_result_t res
);

    int_rs_types::lane_state_t  state;
    int_rs_types::issue_pkt_t   uop;    // held micro-op.
    int_rs_types::issue_pkt_t   cur;
    logic [cpu_params::XLEN-1:0] result;
    logic [cpu_params::XLEN-1:0] op1;
    logic [cpu_params::XLEN-1:0] op2;
    logic [cpu_params::XLEN-1:0] alu_out;
    logic                        rdy1_nxt;
    logic                        rdy2_nxt;

    // ==============================
    // wakeup
    // ==============================
    assign cur = (state == int_rs_types::st_idle) ? pkt : uop;

    always_comb begin
        rdy1_nxt = cur.rs1_rdy;
        rdy2_nxt = cur.rs2_rdy;
        for (int s = 0; s < cpu_params::CDB_WIDTH; s++) begin
            rdy1_nxt |= cdb[s].valid && (cdb[s].rd_phy == cur.rs1_phy);
            rdy2_nxt |= cdb[s].valid && (cdb[s].rd_phy == cur.rs2_phy);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= int_rs_types::st_idle;
        end else begin
            case (state)
                int_rs_types::st_idle: begin
                    if (load) begin
                        state <= (rdy1_nxt && rdy2_nxt) ? int_rs_types::st_exec
                                                        : int_rs_types::st_wait;
                    end
                end
                int_rs_types::st_wait: begin
                    if (rdy1_nxt && rdy2_nxt) state <= int_rs_types::st_exec;
                end
                int_rs_types::st_exec: state <= int_rs_types::st_done;
                default: begin
                    if (res_ready) state <= int_rs_types::st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == int_rs_types::st_idle && load) begin
            uop         <= pkt;
            uop.rs1_rdy <= rdy1_nxt;
            uop.rs2_rdy <= rdy2_nxt;
        end else if (state == int_rs_types::st_wait) begin
            uop.rs1_rdy <= rdy1_nxt;
            uop.rs2_rdy <= rdy2_nxt;
        end
        if (state == int_rs_types::st_exec) result <= alu_out;
    end

    // ==============================
    // operands and alu
    // ==============================
    assign rd_req.rs1_phy = uop.rs1_phy;
    assign rd_req.rs2_phy = uop.rs2_phy;

    assign op1 = rd_rsp.rs1_value;
    assign op2 = uop.imm_en ? uop.imm : rd_rsp.rs2_value;

    always_comb begin
        case (uop.op)
            int_rs_types::op_add: alu_out = op1 + op2;
            int_rs_types::op_sub: alu_out = op1 - op2;
            int_rs_types::op_and: alu_out = op1 & op2;
            int_rs_types::op_or:  alu_out = op1 | op2;
            int_rs_types::op_xor: alu_out = op1 ^ op2;
            int_rs_types::op_sll: alu_out = op1 << op2[4:0];
            int_rs_types::op_srl: alu_out = op1 >> op2[4:0];
            int_rs_types::op_slt: alu_out = {31'd0, $signed(op1) < $signed(op2)};
            default:              alu_out = '0;
        endcase
    end

    assign idle         = (state == int_rs_types::st_idle);
    assign res_valid    = (state == int_rs_types::st_done);  // held until granted.
    assign res.rd_phy   = uop.rd_phy;
    assign res.rd_value = result;

endmodule

`default_nettype wire

//--- issue_router.sv
`timescale 1ns/10ps
`default_nettype none

module issue_router (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issue_valid,
    input  int_rs_types::issue_pkt_t issue,
    output logic                    issue_ready,
    input  logic                    lane_idle [cpu_params::NUM_LANES],
    output logic                    lane_load [cpu_params::NUM_LANES],
    output int_rs_types::issue_pkt_t lane_pkt,
    input  int_rs_types::cdb_prf_t  cdb [cpu_params::CDB_WIDTH]
);

    logic [cpu_params::LANE_W-1:0] sel;
    logic                          fire;
    logic                          hit1;
    logic                          hit2;
    logic                          pend1;   // tags seen while the issue was stalled.
    logic                          pend2;

    // lowest idle lane wins.
    always_comb begin
        sel         = '0;
        issue_ready = 1'b0;
        for (int i = cpu_params::NUM_LANES - 1; i >= 0; i--) begin
            if (lane_idle[i]) begin
                sel         = i[cpu_params::LANE_W-1:0];
                issue_ready = 1'b1;
            end
        end
    end

    assign fire = issue_valid && issue_ready;

    always_comb begin
        for (int i = 0; i < cpu_params::NUM_LANES; i++) begin
            lane_load[i] = fire && (sel == i[cpu_params::LANE_W-1:0]);
        end
    end

    // broadcasts this cycle.
    always_comb begin
        hit1 = 1'b0;
        hit2 = 1'b0;
        for (int s = 0; s < cpu_params::CDB_WIDTH; s++) begin
            hit1 |= cdb[s].valid && (cdb[s].rd_phy == issue.rs1_phy);
            hit2 |= cdb[s].valid && (cdb[s].rd_phy == issue.rs2_phy);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || fire) begin
            pend1 <= 1'b0;
            pend2 <= 1'b0;
        end else if (issue_valid) begin
            pend1 <= pend1 | hit1;
            pend2 <= pend2 | hit2;
        end
    end

    always_comb begin
        lane_pkt         = issue;
        lane_pkt.rs1_rdy = issue.rs1_rdy | pend1 | hit1;
        lane_pkt.rs2_rdy = issue.rs2_rdy | pend2 | hit2;
    end

endmodule

`default_nettype wire

//--- int_rs_types.sv
`default_nettype none

package int_rs_types;

    // ==============================
    // encodings
    // ==============================
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_sll = 3'd5,
        op_srl = 3'd6,
        op_slt = 3'd7    // signed compare.
    } alu_op_t;

    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_wait = 2'd1,
        st_exec = 2'd2,
        st_done = 2'd3
    } lane_state_t;

    // ==============================
    // block to block traffic
    // ==============================
    typedef struct packed {
        alu_op_t                        op;
        logic [cpu_params::PHY_W-1:0]   rd_phy;
        logic [cpu_params::PHY_W-1:0]   rs1_phy;
        logic [cpu_params::PHY_W-1:0]   rs2_phy;
        logic                           rs1_rdy;
        logic                           rs2_rdy;
        logic                           imm_en;   // operand 2 is imm.
        logic [cpu_params::XLEN-1:0]    imm;
    } issue_pkt_t;

    typedef struct packed {
        logic [cpu_params::PHY_W-1:0]   rs1_phy;
        logic [cpu_params::PHY_W-1:0]   rs2_phy;
    } prf_rd_req_t;

    typedef struct packed {
        logic [cpu_params::XLEN-1:0]    rs1_value;
        logic [cpu_params::XLEN-1:0]    rs2_value;
    } prf_rd_rsp_t;

    typedef struct packed {
        logic [cpu_params::PHY_W-1:0]   rd_phy;
        logic [cpu_params::XLEN-1:0]    rd_value;
    } lane_result_t;

    typedef struct packed {
        logic                           valid;
        logic [cpu_params::PHY_W-1:0]   rd_phy;
        logic [cpu_params::XLEN-1:0]    rd_value;
    } cdb_prf_t;

endpackage

`default_nettype wire

//--- cpu_params.sv
`default_nettype none

package cpu_params;

    // ==============================
    // datapath
    // ==============================
    localparam int XLEN      = 32;

    // ==============================
    // physical register file
    // ==============================
    localparam int PRF_DEPTH = 64;
    localparam int PHY_W     = $clog2(PRF_DEPTH);  // 6 bits.

    // ==============================
    // execution cluster
    // ==============================
    localparam int NUM_LANES = 4;
    localparam int CDB_WIDTH = 2;                  // results broadcast per cycle.
    localparam int LANE_W    = $clog2(NUM_LANES);

endpackage

`default_nettype wire
